// ==== logic/sa_cfg.svh ====
`ifndef SA_CFG_SVH
`define SA_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// word format
////////////////////////////////////////////////////////////////////////////

// 16 bit q2.13: 1 sign, 2 int, 13 frac
`define SA_D_W      16
`define SA_FRAC     13

////////////////////////////////////////////////////////////////////////////
// array geometry
////////////////////////////////////////////////////////////////////////////

// rows take x from the left, cols take w from the top
`define SA_ROWS     4
`define SA_COLS     4

////////////////////////////////////////////////////////////////////////////
// sequencer
////////////////////////////////////////////////////////////////////////////

// steps per pass, 1..255 usable
`define SA_LEN_W    8

`endif

// ==== logic/sa_num_pkg.sv ====
`default_nettype none

`include "sa_cfg.svh"

package sa_num_pkg;

    ////////////////////////////////////////////////////////////////////////
    // fixed point word
    ////////////////////////////////////////////////////////////////////////

    // one word, two views
    // raw is used for add and compare
    // f splits the sign off for overflow tests
    typedef union packed {
        logic signed [`SA_D_W-1:0] raw;             // plain two's complement
        struct packed {
            logic                          sgn;     // sign bit
            logic [`SA_D_W-`SA_FRAC-2:0]   ip;      // integer part
            logic [`SA_FRAC-1:0]           fp;      // fraction part
        } f;
    } q_word_t;

    ////////////////////////////////////////////////////////////////////////
    // saturation limits
    ////////////////////////////////////////////////////////////////////////

    // largest positive, just under +4.0
    localparam logic signed [`SA_D_W-1:0] q_max = {1'b0, {(`SA_D_W-1){1'b1}}};

    // most negative, exactly -4.0
    localparam logic signed [`SA_D_W-1:0] q_min = {1'b1, {(`SA_D_W-1){1'b0}}};

endpackage

`default_nettype wire

// ==== logic/sa_ctrl_pkg.sv ====
`default_nettype none

`include "sa_cfg.svh"

package sa_ctrl_pkg;

    // pass sequencer states
    typedef enum logic [1:0] {
        S_IDLE  = 2'd0,     // waiting for start
        S_CLEAR = 2'd1,     // bias preload cycle
        S_RUN   = 2'd2,     // array valid high
        S_DONE  = 2'd3      // one cycle result strobe
    } seq_state_t;

    // extra cycles after the last step until the far corner pe
    // has taken its final product
    localparam int drain_cycles = `SA_ROWS + `SA_COLS - 1;

endpackage

`default_nettype wire

// ==== logic/sa_pe.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sa_cfg.svh"

// one processing element of the output stationary grid
// operands are registered first, the product is taken from the registers
module sa_pe import sa_num_pkg::*; (
    input  wire logic                      I_CLK,
    input  wire logic                      I_ASYN_RSTN,
    input  wire logic                      clear,     // load bias into acc
    input  wire logic                      vld,       // accumulate enable
    input  wire logic signed [`SA_D_W-1:0] x,         // from left
    input  wire logic signed [`SA_D_W-1:0] w,         // from top
    input  wire logic signed [`SA_D_W-1:0] bias,      // preload word
    output logic                           vld_o,     // to next pe
    output logic signed [`SA_D_W-1:0]      x_o,       // to the right
    output logic signed [`SA_D_W-1:0]      w_o,       // downward
    output q_word_t                        acc        // running result
);

    logic signed [2*`SA_D_W-1:0] prod;      // full q4.26 product
    logic signed [2*`SA_D_W-1:0] prod_sh;   // back to q.13, still wide
    q_word_t                     addend;    // product clipped to one word
    q_word_t                     sum;
    q_word_t                     acc_nxt;

    assign prod    = x_o * w_o;
    assign prod_sh = prod >>> `SA_FRAC;     // truncation toward -inf

    // clip the rescaled product before it meets the acc
    always_comb begin
        if (prod_sh > q_max)
            addend.raw = q_max;
        else if (prod_sh < q_min)
            addend.raw = q_min;
        else
            addend.raw = prod_sh[`SA_D_W-1:0];
    end

    // saturating add, overflow seen on the sign fields
    always_comb begin
        sum.raw = acc.raw + addend.raw;
        if (!acc.f.sgn && !addend.f.sgn && sum.f.sgn)
            acc_nxt.raw = q_max;                    // pos + pos went negative
        else if (acc.f.sgn && addend.f.sgn && !sum.f.sgn)
            acc_nxt.raw = q_min;                    // neg + neg went positive
        else
            acc_nxt = sum;
    end

    always_ff @(posedge I_CLK or negedge I_ASYN_RSTN) begin
        if (!I_ASYN_RSTN) begin
            x_o     <= '0;
            w_o     <= '0;
            vld_o   <= 1'b0;
            acc.raw <= '0;
        end else begin
            x_o   <= x;                             // operands always move on
            w_o   <= w;
            vld_o <= clear ? 1'b0 : vld;            // clear kills a stale wavefront
            if (clear)
                acc.raw <= bias;
            else if (vld)
                acc <= acc_nxt;
        end
    end

endmodule

`default_nettype wire

// ==== logic/sa_skew.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sa_cfg.svh"

// triangular input skew
// lane k is held back k cycles so that matching operands meet in the grid
module sa_skew #(
    parameter int lanes = 4
) (
    input  wire logic                      I_CLK,
    input  wire logic                      I_ASYN_RSTN,
    input  wire logic                      feed,               // vectors valid
    input  wire logic signed [`SA_D_W-1:0] din  [0:lanes-1],
    output logic signed [`SA_D_W-1:0]      dout [0:lanes-1]
);

    logic signed [`SA_D_W-1:0] din_g [0:lanes-1];   // zero outside the window

    genvar k;
    generate
        for (k = 0; k < lanes; k++) begin : g_lane

            assign din_g[k] = feed ? din[k] : '0;

            if (k == 0) begin : g_pass
                // no delay, pe 0,0 registers it
                assign dout[k] = din_g[k];
            end else begin : g_dly
                logic signed [`SA_D_W-1:0] sr [0:k-1];   // k deep shift reg

                always_ff @(posedge I_CLK or negedge I_ASYN_RSTN) begin
                    if (!I_ASYN_RSTN) begin
                        for (int m = 0; m < k; m++) begin
                            sr[m] <= '0;
                        end
                    end else begin
                        sr[0] <= din_g[k];
                        for (int m = 1; m < k; m++) begin
                            sr[m] <= sr[m-1];            // shift toward the tap
                        end
                    end
                end

                assign dout[k] = sr[k-1];
            end

        end
    endgenerate

endmodule

`default_nettype wire

// ==== logic/sa_array.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sa_cfg.svh"

// rows x cols grid of pe
// x moves right, w moves down, results stay in place
module sa_array import sa_num_pkg::*; (
    input  wire logic                      I_CLK,
    input  wire logic                      I_ASYN_RSTN,
    input  wire logic                      clear,                         // bias preload
    input  wire logic                      vld,                           // run valid
    input  wire logic signed [`SA_D_W-1:0] x_in   [0:`SA_ROWS-1],         // skewed x
    input  wire logic signed [`SA_D_W-1:0] w_in   [0:`SA_COLS-1],         // skewed w
    input  wire logic signed [`SA_D_W-1:0] bias_d [0:`SA_ROWS-1][0:`SA_COLS-1],
    output logic                           busy,
    output q_word_t                        out    [0:`SA_ROWS-1][0:`SA_COLS-1]
);

    // registered outputs of every pe
    logic signed [`SA_D_W-1:0] x_mat   [0:`SA_ROWS-1][0:`SA_COLS-1];
    logic signed [`SA_D_W-1:0] w_mat   [0:`SA_ROWS-1][0:`SA_COLS-1];
    logic                      vld_mat [0:`SA_ROWS-1][0:`SA_COLS-1];

    ////////////////////////////////////////////////////////////////////////
    // grid
    ////////////////////////////////////////////////////////////////////////
    //
    //            w_in[0]  w_in[1] ..
    //               |        |
    //   x_in[0] -> pe00 --> pe01 --> ..
    //               |        |
    //   x_in[1] -> pe10 --> pe11 --> ..
    //
    // valid enters at pe00 and walks right along each row,
    // column 0 hands it down, so pe(i,j) sees it i+j cycles late,
    // in step with the skewed operands

    genvar i, j;
    generate
        for (i = 0; i < `SA_ROWS; i++) begin : g_row
            for (j = 0; j < `SA_COLS; j++) begin : g_col
                logic signed [`SA_D_W-1:0] x_src;
                logic signed [`SA_D_W-1:0] w_src;
                logic                      vld_src;

                if (j == 0) begin : g_x_edge
                    assign x_src = x_in[i];             // left edge
                end else begin : g_x_int
                    assign x_src = x_mat[i][j-1];
                end

                if (i == 0) begin : g_w_edge
                    assign w_src = w_in[j];             // top edge
                end else begin : g_w_int
                    assign w_src = w_mat[i-1][j];
                end

                if (i == 0 && j == 0) begin : g_v_org
                    assign vld_src = vld;
                end else if (j == 0) begin : g_v_down
                    assign vld_src = vld_mat[i-1][0];   // column 0 feeds rows
                end else begin : g_v_right
                    assign vld_src = vld_mat[i][j-1];
                end

                sa_pe u_pe (
                    .I_CLK       (I_CLK),
                    .I_ASYN_RSTN (I_ASYN_RSTN),
                    .clear       (clear),
                    .vld         (vld_src),
                    .x           (x_src),
                    .w           (w_src),
                    .bias        (bias_d[i][j]),
                    .vld_o       (vld_mat[i][j]),
                    .x_o         (x_mat[i][j]),
                    .w_o         (w_mat[i][j]),
                    .acc         (out[i][j])
                );
            end
        end
    endgenerate

    assign busy = vld_mat[0][0];    // pe00 registered valid

endmodule

`default_nettype wire

// ==== logic/sa_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sa_cfg.svh"

// pass sequencer
// start -> one clear cycle -> len+drain run cycles -> one done cycle
module sa_seq import sa_ctrl_pkg::*; (
    input  wire logic                 I_CLK,
    input  wire logic                 I_ASYN_RSTN,
    input  wire logic                 start,        // one cycle, aborts any pass
    input  wire logic [`SA_LEN_W-1:0] len,          // steps in this pass
    output logic                      clear,        // bias preload strobe
    output logic                      vld,          // array valid
    output logic                      end_flag,     // last run cycle
    output logic                      done          // results final
);

    // one spare bit for len + drain
    localparam int CNT_W = `SA_LEN_W + 1;

    seq_state_t       state;
    logic [CNT_W-1:0] cnt;      // run cycles left

    ////////////////////////////////////////////////////////////////////////
    // fsm
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge I_CLK or negedge I_ASYN_RSTN) begin
        if (!I_ASYN_RSTN) begin
            state <= S_IDLE;
            cnt   <= '0;
        end else if (start) begin
            // restart from any state
            state <= S_CLEAR;
            cnt   <= CNT_W'(len) + CNT_W'(drain_cycles);
        end else begin
            case (state)
                S_CLEAR: begin
                    state <= S_RUN;
                end
                S_RUN: begin
                    cnt <= cnt - 1'b1;
                    if (end_flag)
                        state <= S_DONE;
                end
                S_DONE: begin
                    state <= S_IDLE;            // done is a single pulse
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // outputs, decoded from state
    ////////////////////////////////////////////////////////////////////////

    assign clear    = (state == S_CLEAR);
    assign vld      = (state == S_RUN);
    assign end_flag = vld && (cnt == CNT_W'(1));  // counter about to run out
    assign done     = (state == S_DONE);

endmodule

`default_nettype wire

// ==== logic/sa_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sa_cfg.svh"

// systolic matmul engine: out = bias_d + X * W
module sa_top import sa_num_pkg::*; (
    input  wire logic                      I_CLK,
    input  wire logic                      I_ASYN_RSTN,
    input  wire logic                      start,
    input  wire logic [`SA_LEN_W-1:0]      len,
    input  wire logic                      feed,
    input  wire logic signed [`SA_D_W-1:0] x_in   [0:`SA_ROWS-1],
    input  wire logic signed [`SA_D_W-1:0] w_in   [0:`SA_COLS-1],
    input  wire logic signed [`SA_D_W-1:0] bias_d [0:`SA_ROWS-1][0:`SA_COLS-1],
    output logic                           busy,
    output logic                           done,
    output q_word_t                        out    [0:`SA_ROWS-1][0:`SA_COLS-1]
);

    logic                      seq_clear;
    logic                      seq_vld;
    logic signed [`SA_D_W-1:0] x_skw [0:`SA_ROWS-1];   // row k late by k
    logic signed [`SA_D_W-1:0] w_skw [0:`SA_COLS-1];   // col k late by k

    sa_seq u_seq (
        .I_CLK       (I_CLK),
        .I_ASYN_RSTN (I_ASYN_RSTN),
        .start       (start),
        .len         (len),
        .clear       (seq_clear),
        .vld         (seq_vld),
        .end_flag    (),                // only used inside the fsm
        .done        (done)
    );

    sa_skew #(.lanes(`SA_ROWS)) u_skew_x (
        .I_CLK       (I_CLK),
        .I_ASYN_RSTN (I_ASYN_RSTN),
        .feed        (feed),
        .din         (x_in),
        .dout        (x_skw)
    );

    sa_skew #(.lanes(`SA_COLS)) u_skew_w (
        .I_CLK       (I_CLK),
        .I_ASYN_RSTN (I_ASYN_RSTN),
        .feed        (feed),
        .din         (w_in),
        .dout        (w_skw)
    );

    sa_array u_array (
        .I_CLK       (I_CLK),
        .I_ASYN_RSTN (I_ASYN_RSTN),
        .clear       (seq_clear),
        .vld         (seq_vld),
        .x_in        (x_skw),
        .w_in        (w_skw),
        .bias_d      (bias_d),
        .busy        (busy),
        .out         (out)
    );

endmodule

`default_nettype wire

// ==== dv/sa_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sa_cfg.svh"

// testbench for the systolic matmul engine
// stimulus and expected results come from a file
module sa_tb import sa_num_pkg::*, sa_ctrl_pkg::*; ();

    localparam int MAX_T = 8;       // tests in the file
    localparam int MAX_S = 16;      // steps per test

    logic                      I_CLK;
    logic                      I_ASYN_RSTN;
    logic                      start;
    logic [`SA_LEN_W-1:0]      len;
    logic                      feed;
    logic signed [`SA_D_W-1:0] x_in   [0:`SA_ROWS-1];
    logic signed [`SA_D_W-1:0] w_in   [0:`SA_COLS-1];
    logic signed [`SA_D_W-1:0] bias_d [0:`SA_ROWS-1][0:`SA_COLS-1];
    logic                      busy;
    logic                      done;
    q_word_t                   out    [0:`SA_ROWS-1][0:`SA_COLS-1];

    // test table filled from the stimulus file
    logic [`SA_LEN_W-1:0] len_m   [0:MAX_T-1];
    int                   abort_m [0:MAX_T-1];                  // junk steps before restart
    logic [`SA_D_W-1:0]   bias_m  [0:MAX_T-1][0:3][0:3];
    logic [`SA_D_W-1:0]   exp_m   [0:MAX_T-1][0:3][0:3];
    logic [`SA_D_W-1:0]   xw_m    [0:MAX_T-1][0:MAX_S-1][0:7];  // x0..x3 then w0..w3

    int fd;
    int n_tests;
    int err_cnt;
    int fail_tests;
    int cyc;
    int cycle_limit = 100000;

    sa_top u_sa_top (
        .I_CLK       (I_CLK),
        .I_ASYN_RSTN (I_ASYN_RSTN),
        .start       (start),
        .len         (len),
        .feed        (feed),
        .x_in        (x_in),
        .w_in        (w_in),
        .bias_d      (bias_d),
        .busy        (busy),
        .done        (done),
        .out         (out)
    );

    always #2 I_CLK = ~I_CLK;       // 4 ns period

    // watchdog
    always @(posedge I_CLK) begin
        cyc <= cyc + 1;
        if (cyc > cycle_limit) begin
            $display("timeout: done did not arrive within %0d cycles", cycle_limit);
            $display("Something failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_val(input string name, input logic [15:0] expv,
                             input logic [15:0] actv);
        if (expv !== actv) begin
            err_cnt++;
            $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, expv, actv);
        end
    endtask

    // next line that is not a comment or blank
    task automatic next_line(output string s, output bit ok);
        int r;
        ok = 1'b0;
        s  = "";
        while (!$feof(fd)) begin
            r = $fgets(s, fd);
            if (r > 0 && s.len() > 1 && s.substr(0, 0) != "#") begin
                ok = 1'b1;
                return;
            end
        end
    endtask

    task automatic read_row(output logic [15:0] v [0:7]);
        string       s;
        bit          ok;
        int          r;
        logic [15:0] v0, v1, v2, v3, v4, v5, v6, v7;
        next_line(s, ok);
        r = $sscanf(s, "%h %h %h %h %h %h %h %h", v0, v1, v2, v3, v4, v5, v6, v7);
        v = '{v0, v1, v2, v3, v4, v5, v6, v7};
    endtask

    task automatic load_tests();
        string       s;
        bit          ok;
        int          r;
        int          l;
        int          a;
        logic [15:0] v [0:7];
        n_tests = 0;
        next_line(s, ok);
        while (ok && n_tests < MAX_T) begin
            r = $sscanf(s, "%d %d", l, a);          // header holds len and abort steps
            len_m[n_tests]   = l[`SA_LEN_W-1:0];
            abort_m[n_tests] = a;
            for (int i = 0; i < 4; i++) begin
                read_row(v);
                for (int j = 0; j < 4; j++) bias_m[n_tests][i][j] = v[j];
            end
            for (int st = 0; st < l; st++) begin
                read_row(v);
                xw_m[n_tests][st] = v;
            end
            for (int i = 0; i < 4; i++) begin
                read_row(v);
                for (int j = 0; j < 4; j++) exp_m[n_tests][i][j] = v[j];
            end
            n_tests++;
            next_line(s, ok);
        end
    endtask

    // behavior right after reset
    task automatic check_idle();
        int errs_before;
        errs_before = err_cnt;
        check_val("done", 16'(0), 16'(done));
        check_val("busy", 16'(0), 16'(busy));
        for (int i = 0; i < `SA_ROWS; i++)
            for (int j = 0; j < `SA_COLS; j++)
                check_val($sformatf("out[%0d][%0d]", i, j), 16'h0000, out[i][j].raw);
        if (err_cnt != errs_before) fail_tests++;
        $display("test reset: %s", (err_cnt == errs_before) ? "ok" : "FAILED");
    endtask

    task automatic run_test(input int t);
        int errs_before;
        errs_before = err_cnt;
        @(posedge I_CLK);
        for (int i = 0; i < `SA_ROWS; i++)
            for (int j = 0; j < `SA_COLS; j++) bias_d[i][j] <= bias_m[t][i][j];
        start <= 1'b1;
        len   <= len_m[t];
        // pass to be aborted with full scale operands that saturate every pe
        for (int st = 0; st < abort_m[t]; st++) begin
            @(posedge I_CLK);
            start <= 1'b0;
            feed  <= 1'b1;
            for (int k = 0; k < 4; k++) x_in[k] <= 16'h4000;
            for (int k = 0; k < 4; k++) w_in[k] <= 16'h4000;
        end
        if (abort_m[t] > 0) begin
            @(posedge I_CLK);
            start <= 1'b1;                      // restart mid pass
            feed  <= 1'b0;
        end
        for (int st = 0; st < len_m[t]; st++) begin
            @(posedge I_CLK);
            start <= 1'b0;
            feed  <= 1'b1;
            for (int k = 0; k < 4; k++) x_in[k] <= xw_m[t][st][k];
            for (int k = 0; k < 4; k++) w_in[k] <= xw_m[t][st][4+k];
        end
        @(posedge I_CLK);
        feed <= 1'b0;
        for (int k = 0; k < 4; k++) x_in[k] <= '0;
        for (int k = 0; k < 4; k++) w_in[k] <= '0;
        @(negedge I_CLK);
        while (!done) @(negedge I_CLK);         // watchdog bounds this
        check_val("busy", 16'(1), 16'(busy));   // pe00 still holds the last run valid
        for (int i = 0; i < `SA_ROWS; i++)
            for (int j = 0; j < `SA_COLS; j++)
                check_val($sformatf("out[%0d][%0d]", i, j), exp_m[t][i][j], out[i][j].raw);
        if (err_cnt != errs_before) fail_tests++;
        $display("test %0d: len %0d, abort after %0d: %s", t + 1, len_m[t], abort_m[t],
                 (err_cnt == errs_before) ? "ok" : "FAILED");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        I_CLK       = 1'b0;
        I_ASYN_RSTN = 1'b0;
        start       = 1'b0;
        len         = '0;
        feed        = 1'b0;
        for (int k = 0; k < `SA_ROWS; k++) x_in[k] = '0;
        for (int k = 0; k < `SA_COLS; k++) w_in[k] = '0;
        for (int i = 0; i < `SA_ROWS; i++)
            for (int j = 0; j < `SA_COLS; j++) bias_d[i][j] = '0;
        err_cnt    = 0;
        fail_tests = 0;
        n_tests    = 0;
        fd = $fopen("dv/sa_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open dv/sa_stimulus.txt");
        end else begin
            load_tests();
            $fclose(fd);
        end
        // reset, margin, then each pass and its restart
        cycle_limit = 16 + 64;
        for (int t = 0; t < n_tests; t++)
            cycle_limit += int'(len_m[t]) + drain_cycles + 2 + abort_m[t] + 3;
        repeat (16) @(posedge I_CLK);
        I_ASYN_RSTN <= 1'b1;
        @(negedge I_CLK);
        check_idle();
        for (int t = 0; t < n_tests; t++) run_test(t);
        $display("summary: %0d tests, %0d failed, %0d mismatches",
                 n_tests + 1, fail_tests, err_cnt);
        if (err_cnt == 0 && n_tests > 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/sa_stimulus.txt ====
# per test: "len abort_steps", 4 bias rows, len rows of "x0 x1 x2 x3 w0 w1 w2 w3",
# then 4 expected result rows; all words are q2.13 hex
# identity weights, zero bias
4 0
0000 0000 0000 0000
0000 0000 0000 0000
0000 0000 0000 0000
0000 0000 0000 0000
1000 2000 F000 0800 2000 0000 0000 0000
E000 0400 3000 0001 0000 2000 0000 0000
0123 FF00 1800 C000 0000 0000 2000 0000
0FFF 2000 E800 7FFF 0000 0000 0000 2000
1000 E000 0123 0FFF
2000 0400 FF00 2000
F000 3000 1800 E800
0800 0001 C000 7FFF
# mixed signs over eight steps
8 0
0000 0000 0000 0000
0000 0000 0000 0000
0000 0000 0000 0000
0000 0000 0000 0000
0800 F000 1800 0000 1000 F800 0000 0800
F800 0800 1000 E800 0800 0800 F000 0000
1000 0000 F800 0800 F800 1800 0800 1000
0000 1800 F000 F800 1000 0000 F800 F000
E800 F800 0800 1000 0000 1000 0800 F800
0800 1000 0000 F000 F000 F800 1800 0800
2000 F800 F800 0800 0800 0000 F800 0800
F000 0800 0800 0000 0800 F000 0000 1800
FE00 0200 0000 0E00
FE00 FA00 0200 FA00
0A00 F800 FE00 0C00
FE00 0C00 0600 0200
# saturation both ways, truncation in the last row
3 0
0000 0000 0000 0000
0000 0000 0000 0000
0000 0000 0000 0000
0000 0000 0000 0000
6000 A000 1000 FFFF 6000 A000 2000 0800
6000 A000 1000 FFFF 6000 A000 2000 0800
6000 A000 1000 FFFF 6000 A000 2000 0800
7FFF 8000 7FFF 4800
8000 7FFF 8000 B800
7FFF 8000 3000 0C00
FFF7 0009 FFFD FFFD
# nonzero bias
2 0
0100 FF00 0010 0001
2000 E000 0200 FE00
0003 FFFD 1000 F000
4000 C000 0000 7000
2000 1000 F000 0000 1000 2000 0800 E000
0800 0800 0800 0800 2000 2000 2000 2000
1900 2700 1010 E801
3000 F800 0E00 F600
0003 F7FD 1400 0800
4800 C800 0800 7800
# restart after three steps of an aborted pass
2 3
0100 0100 0100 0100
0100 0100 0100 0100
0100 0100 0100 0100
0100 0100 0100 0100
2000 2000 2000 2000 0800 1000 1800 2000
F000 0000 0000 1000 2000 2000 2000 2000
F900 0100 0900 1100
0900 1100 1900 2100
0900 1100 1900 2100
1900 2100 2900 3100

// ==== src.f ====
+incdir+logic
logic/sa_num_pkg.sv
logic/sa_ctrl_pkg.sv
logic/sa_pe.sv
logic/sa_skew.sv
logic/sa_array.sv
logic/sa_seq.sv
logic/sa_top.sv
dv/sa_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f src.f --top-module sa_tb -o sa_sim

sim_out=$(./obj_dir/sa_sim)
echo "$sim_out"

if echo "$sim_out" | grep -qx "Everything OK"; then
    exit 0
else
    exit 1
fi
